// ==== verilog/clkGenPkg.sv ====
// Clock generator shared definitions: field widths, field types and control states
package clkGenPkg;

  // -------------------------------------------------------------------------
  // Field widths
  // -------------------------------------------------------------------------

  // Integer half-period, counted in prescaled ticks
  localparam int DIV_INT_W  = 8;

  // Fractional half-period and accumulator
  // One unit is 1/64 of a tick
  localparam int DIV_FRAC_W = 6;

  // Prescale select, tick rate is input / 2**p
  localparam int PRESCALE_W = 2;

  // Prescale counter must reach 2**(2**PRESCALE_W - 1) - 1
  localparam int PRE_CNT_W  = 2 ** PRESCALE_W - 1;

  // Lock settle window, in input cycles
  localparam int LOCK_W     = 10;

  // -------------------------------------------------------------------------
  // Field types
  // -------------------------------------------------------------------------

  typedef logic [DIV_INT_W-1:0]  divIntT;
  typedef logic [DIV_FRAC_W-1:0] divFracT;
  typedef logic [PRESCALE_W-1:0] prescaleT;
  typedef logic [LOCK_W-1:0]     lockWinT;

  // Control FSM
  // RESTART is also the state out of reset
  typedef enum logic [1:0] {
    IDLE,
    CAPTURE,
    ACK_HIGH,
    RESTART
  } ctrlStateT;

endpackage

// ==== verilog/clkGenCtrl.sv ====
// Clock generator control: four-phase config handshake, shadow registers, restart
`timescale 1ns/1ns

module clkGenCtrl (
  input  logic                CK_XTAL_IN,
  input  logic                rstn,
  // Host handshake
  input  logic                cfgReq,
  output logic                cfgAck,
  // Configuration, stable while cfgReq is high
  input  logic                ps0En,
  input  logic                ps1En,
  input  logic                ps0Bypass,
  input  logic                ps1Bypass,
  input  clkGenPkg::prescaleT ps0Prescale,
  input  clkGenPkg::prescaleT ps1Prescale,
  input  clkGenPkg::divIntT   ps0DivInt,
  input  clkGenPkg::divIntT   ps1DivInt,
  input  clkGenPkg::divFracT  ps0DivFrac,
  input  clkGenPkg::divFracT  ps1DivFrac,
  input  clkGenPkg::lockWinT  lockWindow,
  // Shadow copies seen by the dividers and the lock timer
  output logic                sh0En,
  output logic                sh1En,
  output logic                sh0Bypass,
  output logic                sh1Bypass,
  output clkGenPkg::prescaleT sh0Prescale,
  output clkGenPkg::prescaleT sh1Prescale,
  output clkGenPkg::divIntT   sh0DivInt,
  output clkGenPkg::divIntT   sh1DivInt,
  output clkGenPkg::divFracT  sh0DivFrac,
  output clkGenPkg::divFracT  sh1DivFrac,
  output clkGenPkg::lockWinT  shLockWindow,
  // Restart sequencing
  output logic                restart,
  input  logic                locked
);

  import clkGenPkg::*;

  ctrlStateT state;
  logic      cfgReqQ;
  logic      capture;

  // Request register, all handshake decisions use this copy
  always_ff @(posedge CK_XTAL_IN or negedge rstn) begin
    if (!rstn) begin
      cfgReqQ <= 1'b0;
    end else begin
      cfgReqQ <= cfgReq;
    end
  end

  // New config only taken from IDLE with ack already dropped
  assign capture = (state == IDLE) && cfgReqQ && !cfgAck;

  // -------------------------------------------------------------------------
  // Handshake FSM
  // -------------------------------------------------------------------------
  // Out of reset the FSM sits in RESTART, so the first edge after release
  // restarts the block with the all-zero shadows
  always_ff @(posedge CK_XTAL_IN or negedge rstn) begin
    if (!rstn) begin
      state  <= RESTART;
      cfgAck <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (capture) begin
            state <= CAPTURE;
          end
        end
        // Shadows loaded, raise ack together with restart
        CAPTURE: begin
          state  <= RESTART;
          cfgAck <= 1'b1;
        end
        // Post-reset pass has no ack; leave once the lock timer reads low
        RESTART: begin
          if (cfgAck) begin
            state <= ACK_HIGH;
          end else if (!locked) begin
            state <= IDLE;
          end
        end
        // Hold ack until the host lets go of the request
        ACK_HIGH: begin
          if (!cfgReqQ) begin
            state  <= IDLE;
            cfgAck <= 1'b0;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // One-cycle pulse, same cycle as the ack rise
  assign restart = (state == RESTART);

  // Shadow registers, whole configuration in a single cycle
  always_ff @(posedge CK_XTAL_IN or negedge rstn) begin
    if (!rstn) begin
      sh0En        <= 1'b0;
      sh1En        <= 1'b0;
      sh0Bypass    <= 1'b0;
      sh1Bypass    <= 1'b0;
      sh0Prescale  <= '0;
      sh1Prescale  <= '0;
      sh0DivInt    <= '0;
      sh1DivInt    <= '0;
      sh0DivFrac   <= '0;
      sh1DivFrac   <= '0;
      shLockWindow <= '0;
    end else if (capture) begin
      sh0En        <= ps0En;
      sh1En        <= ps1En;
      sh0Bypass    <= ps0Bypass;
      sh1Bypass    <= ps1Bypass;
      sh0Prescale  <= ps0Prescale;
      sh1Prescale  <= ps1Prescale;
      sh0DivInt    <= ps0DivInt;
      sh1DivInt    <= ps1DivInt;
      sh0DivFrac   <= ps0DivFrac;
      sh1DivFrac   <= ps1DivFrac;
      shLockWindow <= lockWindow;
    end
  end

endmodule

// ==== verilog/postDivider.sv ====
// Post divider: power-of-two prescale, fractional half-period, AUX clock bypass
`timescale 1ns/1ns

module postDivider (
  input  logic                CK_XTAL_IN,
  input  logic                rstn,
  input  logic                CK_AUX_IN,
  // Channel settings from the shadow registers
  input  logic                en,
  input  logic                bypass,
  input  clkGenPkg::prescaleT prescale,
  input  clkGenPkg::divIntT   divInt,
  input  clkGenPkg::divFracT  divFrac,
  // Sequencing
  input  logic                restart,
  input  logic                locked,
  // Divided clock
  output logic                ckOut
);

  import clkGenPkg::*;

  logic [PRE_CNT_W-1:0]  preCnt;
  logic [PRE_CNT_W-1:0]  preTerm;
  logic                  tick;
  logic [DIV_INT_W:0]    halfCnt;
  logic [DIV_INT_W:0]    halfLast;
  logic [DIV_FRAC_W-1:0] fracAcc;
  logic [DIV_FRAC_W:0]   fracSum;
  logic                  fracCarry;
  logic                  active;
  logic                  ckDiv;

  // Runs only after lock, on an enabled, unbypassed channel
  assign active = locked && en && !bypass;

  // -------------------------------------------------------------------------
  // Prescaler
  // -------------------------------------------------------------------------
  // Terminal count 2**prescale - 1, the low prescale bits all set
  assign preTerm = ~({PRE_CNT_W{1'b1}} << prescale);
  assign tick    = active && (preCnt == preTerm);

  always_ff @(posedge CK_XTAL_IN or negedge rstn) begin
    if (!rstn) begin
      preCnt <= '0;
    end else if (restart) begin
      preCnt <= '0;
    end else if (active) begin
      preCnt <= tick ? '0 : preCnt + 1'b1;
    end
  end

  // -------------------------------------------------------------------------
  // Half-period counter and fractional accumulator
  // -------------------------------------------------------------------------
  // Add divFrac once per half-period, the carry stretches this one by a tick
  assign fracSum   = {1'b0, fracAcc} + {1'b0, divFrac};
  assign fracCarry = fracSum[DIV_FRAC_W];

  // divInt+1 ticks, or divInt+2 on overflow
  assign halfLast = {1'b0, divInt} + {{DIV_INT_W{1'b0}}, fracCarry};

  always_ff @(posedge CK_XTAL_IN or negedge rstn) begin
    if (!rstn) begin
      halfCnt <= '0;
      fracAcc <= '0;
      ckDiv   <= 1'b0;
    end else if (restart) begin
      halfCnt <= '0;
      fracAcc <= '0;
      ckDiv   <= 1'b0;
    end else if (tick) begin
      if (halfCnt == halfLast) begin
        // End of half-period
        halfCnt <= '0;
        fracAcc <= fracSum[DIV_FRAC_W-1:0];
        ckDiv   <= ~ckDiv;
      end else begin
        halfCnt <= halfCnt + 1'b1;
      end
    end
  end

  // Bypass wins regardless of lock; a disabled channel is held low
  assign ckOut = bypass ? CK_AUX_IN : (en & ckDiv);

endmodule

// ==== verilog/lockTimer.sv ====
// Lock timer: holds locked low for a settle window after every restart
`timescale 1ns/1ns

module lockTimer (
  input  logic               CK_XTAL_IN,
  input  logic               rstn,
  // One-cycle pulse from the control FSM
  input  logic               restart,
  // Settle length, sampled on the restart edge
  input  clkGenPkg::lockWinT window,
  output logic               locked
);

  import clkGenPkg::*;

  lockWinT settleCnt;
  logic    settleDone;

  // Count exhausted, lock on the next edge
  assign settleDone = (settleCnt == '0);

  // -------------------------------------------------------------------------
  // Settle counter
  // -------------------------------------------------------------------------
  // Restart edge: locked drops and the count loads window
  // window edges of countdown, then one more edge raises locked,
  // i.e. window+1 edges after the drop
  always_ff @(posedge CK_XTAL_IN or negedge rstn) begin
    if (!rstn) begin
      settleCnt <= '0;
      locked    <= 1'b0;
    end else if (restart) begin
      settleCnt <= window;
      locked    <= 1'b0;
    end else if (!settleDone) begin
      settleCnt <= settleCnt - 1'b1;
    end else begin
      // holds high until the next restart
      locked    <= 1'b1;
    end
  end

endmodule

// ==== verilog/clkGenTop.sv ====
// Clock generator top: control FSM, lock timer and the two output dividers
`timescale 1ns/1ns

module clkGenTop (
  input  logic                CK_XTAL_IN,
  input  logic                CK_AUX_IN,
  input  logic                rstn,
  // Host handshake
  input  logic                cfgReq,
  output logic                cfgAck,
  // Configuration
  input  logic                ps0En,
  input  logic                ps1En,
  input  logic                ps0Bypass,
  input  logic                ps1Bypass,
  input  clkGenPkg::prescaleT ps0Prescale,
  input  clkGenPkg::prescaleT ps1Prescale,
  input  clkGenPkg::divIntT   ps0DivInt,
  input  clkGenPkg::divFracT  ps0DivFrac,
  input  clkGenPkg::divIntT   ps1DivInt,
  input  clkGenPkg::divFracT  ps1DivFrac,
  input  clkGenPkg::lockWinT  lockWindow,
  // Outputs
  output logic                ckPllDiv0,
  output logic                ckPllDiv1,
  output logic                locked
);

  import clkGenPkg::*;

  // Shadow configuration
  logic     sh0En;
  logic     sh1En;
  logic     sh0Bypass;
  logic     sh1Bypass;
  prescaleT sh0Prescale;
  prescaleT sh1Prescale;
  divIntT   sh0DivInt;
  divIntT   sh1DivInt;
  divFracT  sh0DivFrac;
  divFracT  sh1DivFrac;
  lockWinT  shLockWindow;
  logic     restart;

  // -------------------------------------------------------------------------
  // Control and lock
  // -------------------------------------------------------------------------
  clkGenCtrl ctrl (.*);

  lockTimer lockTmr (
    .CK_XTAL_IN (CK_XTAL_IN),
    .rstn       (rstn),
    .restart    (restart),
    .window     (shLockWindow),
    .locked     (locked)
  );

  // -------------------------------------------------------------------------
  // Output channels
  // -------------------------------------------------------------------------
  postDivider div0 (
    .CK_XTAL_IN (CK_XTAL_IN), .rstn (rstn), .CK_AUX_IN (CK_AUX_IN),
    .en         (sh0En),      .bypass (sh0Bypass), .prescale (sh0Prescale),
    .divInt     (sh0DivInt),  .divFrac (sh0DivFrac),
    .restart    (restart),    .locked (locked),    .ckOut (ckPllDiv0)
  );

  postDivider div1 (
    .CK_XTAL_IN (CK_XTAL_IN), .rstn (rstn), .CK_AUX_IN (CK_AUX_IN),
    .en         (sh1En),      .bypass (sh1Bypass), .prescale (sh1Prescale),
    .divInt     (sh1DivInt),  .divFrac (sh1DivFrac),
    .restart    (restart),    .locked (locked),    .ckOut (ckPllDiv1)
  );

endmodule

// ==== dv/clkGenTb_chk.sv ====
// Clock generator control checker for the handshake and lock-drop rules
`timescale 1ns/1ns

module clkGenTb_chk (
  input logic CK_XTAL_IN,
  input logic rstn,
  input logic cfgReq,
  input logic cfgAck,
  input logic restart,
  input logic locked
);

  // --------------------------------------------------------------------------
  // Handshake
  // --------------------------------------------------------------------------

  // Ack only answers a request the host still holds
  ackNeedsReq: assert property (
    @(posedge CK_XTAL_IN) disable iff (!rstn)
    $rose(cfgAck) |-> $past(cfgReq)
  ) else $error("cfgAck rose without cfgReq");

  // Low request first seen while ack is high
  // Ack still high on the next edge and gone on the one after
  ackRelease: assert property (
    @(posedge CK_XTAL_IN) disable iff (!rstn)
    (cfgAck && $fell(cfgReq)) |=> cfgAck ##1 !cfgAck
  ) else $error("cfgAck did not fall one edge after cfgReq went low");

  // --------------------------------------------------------------------------
  // Lock
  // --------------------------------------------------------------------------

  // Every restart drops lock
  lockDrop: assert property (
    @(posedge CK_XTAL_IN) disable iff (!rstn)
    restart |=> !locked
  ) else $error("locked still high after restart");

endmodule

bind clkGenCtrl clkGenTb_chk chk (.*);

// ==== dv/clkGenTbTable.svh ====
// Clock generator testbench table holding one channel configuration per row
`ifndef CLKGENTBTABLE_SVH
`define CLKGENTBTABLE_SVH

// Column order en0 en1 byp0 byp1 pre0 pre1 int0 frac0 int1 frac1 lockWindow
typedef struct {
  logic     en0, en1, byp0, byp1;
  prescaleT pre0, pre1;
  divIntT   int0;
  divFracT  frac0;
  divIntT   int1;
  divFracT  frac1;
  lockWinT  win;
} rowT;

localparam int NUM_ROWS = 6;

rowT cfgTable[NUM_ROWS] = '{
  // Integer only on both channels
  '{1'b1, 1'b1, 1'b0, 1'b0, 2'd0, 2'd0, 8'd3, 6'd0,  8'd5, 6'd0,  10'd12},
  // Fractional with prescale on both channels
  '{1'b1, 1'b1, 1'b0, 1'b0, 2'd1, 2'd2, 8'd2, 6'd5,  8'd4, 6'd33, 10'd20},
  // Channel 1 disabled
  '{1'b1, 1'b0, 1'b0, 1'b0, 2'd3, 2'd0, 8'd1, 6'd63, 8'd0, 6'd0,  10'd7},
  // Channel 0 bypassed with a zero lock window
  '{1'b0, 1'b1, 1'b1, 1'b0, 2'd0, 2'd1, 8'd0, 6'd0,  8'd6, 6'd17, 10'd0},
  // Channel 1 bypassed while enabled
  '{1'b1, 1'b1, 1'b0, 1'b1, 2'd2, 2'd0, 8'd9, 6'd40, 8'd0, 6'd0,  10'd30},
  // Shortest half-periods
  '{1'b1, 1'b1, 1'b0, 1'b0, 2'd0, 2'd0, 8'd0, 6'd1,  8'd0, 6'd63, 10'd1}
};

`endif

// ==== dv/clkGenTb.sv ====
// Clock generator testbench applying table rows to check handshake, lock and dividers
`timescale 1ns/1ns

module clkGenTb #(parameter int SEED = 33873);

  import clkGenPkg::*;
  `include "clkGenTbTable.svh"

  // Clock half-periods in ns
  localparam int XTAL_HALF    = 10;
  localparam int AUX_HALF     = 13;
  // Wait limits in input cycles
  localparam int ACK_TIMEOUT  = 10;
  localparam int MEAS_TIMEOUT = 300000;

  logic CK_XTAL_IN, CK_AUX_IN, rstn, cfgReq;
  logic ps0En, ps1En, ps0Bypass, ps1Bypass;
  prescaleT ps0Prescale, ps1Prescale;
  divIntT   ps0DivInt, ps1DivInt;
  divFracT  ps0DivFrac, ps1DivFrac;
  lockWinT  lockWindow;
  logic cfgAck, ckPllDiv0, ckPllDiv1, locked;
  int   cyc;
  int   seed;
  rowT  rows[$];
  rowT  rnd;

  clkGenTop uut (.*);

  // Crystal clock
  initial begin
    CK_XTAL_IN = 1'b0;
    forever #XTAL_HALF CK_XTAL_IN = ~CK_XTAL_IN;
  end

  // Auxiliary clock for bypass, unrelated to the crystal
  initial begin
    CK_AUX_IN = 1'b0;
    forever #AUX_HALF CK_AUX_IN = ~CK_AUX_IN;
  end

  // Input edge counter read 1 ns after each rising edge
  initial cyc = 0;
  always @(posedge CK_XTAL_IN) cyc <= cyc + 1;

  // --------------------------------------------------------------------------
  // Failure reporting and compare tasks
  // --------------------------------------------------------------------------
  task automatic failNow(string msg);
    $display("[FAIL] t=%0t %s", $time, msg);
    $display("test failed");
    $fatal(1, "stopping on first mismatch");
  endtask

  task automatic timeoutAbort(string what);
    $display("Timed out while waiting for %s", what);
    $display("test failed");
    $fatal(1, "stopping on timeout");
  endtask

  task automatic checkLevel(string what, logic got, logic exp);
    if (got !== exp) failNow($sformatf("%s is %b, expected %b", what, got, exp));
  endtask

  // Handshake edge distances in input cycles
  task automatic checkHandshake(string what, int measured, int exp);
    if (measured != exp) begin
      failNow($sformatf("%s after %0d edges, expected %0d", what, measured, exp));
    end
  endtask

  // Lock rises window+1 edges after the drop
  task automatic checkLock(lockWinT win, int measured);
    int exp;
    exp = int'(win) + 1;
    if (measured != exp) failNow($sformatf("lock after %0d edges, expected %0d", measured, exp));
  endtask

  // 64 half-periods take 2**p * (64*(divInt+1) + divFrac) input cycles
  task automatic checkPeriod(divIntT dInt, divFracT dFrac, prescaleT pre, int measured);
    int exp;
    exp = (64 * (int'(dInt) + 1) + int'(dFrac)) << pre;
    if (measured != exp) begin
      failNow($sformatf("64 half-periods int=%0d frac=%0d pre=%0d took %0d, expected %0d",
                        dInt, dFrac, pre, measured, exp));
    end
  endtask

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  // Step to 1 ns past the next input edge
  task automatic sampleEdge();
    @(posedge CK_XTAL_IN);
    #1;
  endtask

  // Bypass follows AUX except at the instants where AUX itself moves
  task automatic checkOne(string name, logic en, logic byp, logic ck);
    if (byp) begin
      if ($time % AUX_HALF != 0) checkLevel({name, " bypass"}, ck, CK_AUX_IN);
    end else if (!en) begin
      checkLevel({name, " disabled"}, ck, 1'b0);
    end else if (!locked) begin
      checkLevel({name, " before lock"}, ck, 1'b0);
    end
  endtask

  task automatic checkChannels(rowT r);
    checkOne("ckPllDiv0", r.en0, r.byp0, ckPllDiv0);
    checkOne("ckPllDiv1", r.en1, r.byp1, ckPllDiv1);
  endtask

  // Count input cycles over 64 half-periods starting at a toggle
  task automatic measure(rowT r, int ch, output int count);
    logic prev;
    int   n;
    int   toggles;
    int   start;
    prev = ch ? ckPllDiv1 : ckPllDiv0;
    n = 0;
    toggles = -1;
    start = 0;
    while (toggles < 64) begin
      sampleEdge();
      checkChannels(r);
      // First toggle opens the span
      if ((ch ? ckPllDiv1 : ckPllDiv0) != prev) begin
        prev = ~prev;
        if (toggles < 0) start = cyc;
        toggles++;
      end
      n++;
      if (n > MEAS_TIMEOUT) timeoutAbort($sformatf("divider %0d half-periods", ch));
    end
    count = cyc - start;
  endtask

  // One full host transaction followed by the lock and divider checks
  task automatic applyRow(rowT r);
    int n;
    int reqCyc;
    int dropCyc;
    int ackFall;
    int lockFall;
    int count;
    // Host starts from a locked block with the handshake idle
    n = 0;
    while (!locked || cfgAck) begin
      sampleEdge();
      n++;
      if (n > MEAS_TIMEOUT) timeoutAbort("lock before a new request");
    end
    // Configuration and request 2 ns after the edge
    #1;
    {ps0En, ps1En, ps0Bypass, ps1Bypass} = {r.en0, r.en1, r.byp0, r.byp1};
    {ps0Prescale, ps1Prescale, lockWindow} = {r.pre0, r.pre1, r.win};
    {ps0DivInt, ps0DivFrac, ps1DivInt, ps1DivFrac} = {r.int0, r.frac0, r.int1, r.frac1};
    cfgReq = 1'b1;
    reqCyc = cyc;
    // Request sampled on the next edge and ack on the second edge after that
    n = 0;
    while (!cfgAck) begin
      sampleEdge();
      n++;
      if (n > ACK_TIMEOUT) timeoutAbort("cfgAck to rise");
    end
    checkHandshake("cfgAck rise", cyc - reqCyc, 3);
    #1;
    cfgReq = 1'b0;
    dropCyc = cyc;
    ackFall = -1;
    lockFall = -1;
    // Track ack release and the lock drop and rise together
    n = 0;
    forever begin
      sampleEdge();
      checkChannels(r);
      if (!cfgAck && ackFall < 0) ackFall = cyc;
      if (!locked && lockFall < 0) lockFall = cyc;
      if (locked && lockFall >= 0) break;
      n++;
      if (n > int'(r.win) + 20) timeoutAbort("lock drop and rise");
    end
    if (ackFall < 0) failNow("cfgAck still high after lock");
    // Low request seen one edge after the drop and ack gone on the next
    checkHandshake("cfgAck fall", ackFall - dropCyc, 2);
    checkLock(r.win, cyc - lockFall);
    if (r.en0 && !r.byp0) begin
      measure(r, 0, count);
      checkPeriod(r.int0, r.frac0, r.pre0, count);
    end
    if (r.en1 && !r.byp1) begin
      measure(r, 1, count);
      checkPeriod(r.int1, r.frac1, r.pre1, count);
    end
    // Disabled or bypassed channels keep watch for a while longer
    repeat (64) begin
      sampleEdge();
      checkChannels(r);
    end
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------
  initial begin
    rstn = 1'b0;
    cfgReq = 1'b0;
    {ps0En, ps1En, ps0Bypass, ps1Bypass} = '0;
    {ps0Prescale, ps1Prescale, lockWindow} = '0;
    {ps0DivInt, ps0DivFrac, ps1DivInt, ps1DivFrac} = '0;
    seed = SEED;
    // Reset held for 4 input cycles
    repeat (4) @(posedge CK_XTAL_IN);
    #1;
    checkLevel("cfgAck in reset", cfgAck, 1'b0);
    checkLevel("locked in reset", locked, 1'b0);
    checkLevel("ckPllDiv0 in reset", ckPllDiv0, 1'b0);
    checkLevel("ckPllDiv1 in reset", ckPllDiv1, 1'b0);
    #1;
    rstn = 1'b1;
    foreach (cfgTable[i]) rows.push_back(cfgTable[i]);
    // Two random rows on top of the first row's enables and window
    repeat (2) begin
      rnd = cfgTable[0];
      rnd.int0 = divIntT'($random(seed));
      rnd.frac0 = divFracT'($random(seed));
      rnd.int1 = divIntT'($random(seed));
      rnd.frac1 = divFracT'($random(seed));
      rnd.pre0 = prescaleT'($random(seed));
      rnd.pre1 = prescaleT'($random(seed));
      rows.push_back(rnd);
    end
    foreach (rows[i]) applyRow(rows[i]);
    $display("test passed");
    $finish;
  end

endmodule

// ==== clkGen.f ====
+incdir+dv
verilog/clkGenPkg.sv
verilog/clkGenCtrl.sv
verilog/postDivider.sv
verilog/lockTimer.sv
verilog/clkGenTop.sv
dv/clkGenTb_chk.sv
dv/clkGenTb.sv

// ==== Makefile ====
# Verilator build and run for the clock generator testbench

TOP      ?= clkGenTb
SEED     ?= 33873
LOG      ?= sim.log
FILELIST ?= clkGen.f
OBJDIR   ?= obj_dir
VERILATOR ?= verilator
VFLAGS   ?= --binary --timing --assert

BIN := $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(wildcard verilog/*.sv) $(wildcard dv/*.sv) $(wildcard dv/*.svh)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -GSEED=$(SEED) \
		--Mdir $(OBJDIR) -o V$(TOP)

run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "test passed" $(LOG); then \
		echo "Simulation PASSED"; \
	else \
		echo "Simulation FAILED"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
